//--- verilog.f
+incdir+.
irqPkg.sv
irqRegBus.sv
irqArbBus.sv
irqRegDecode.sv
irqFlagUnit.sv
irqPriority.sv
irqController.sv
tb_irqController.sv

//--- run.sh
#!/bin/bash
# Build with Verilator, run, then scan the simulation log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_irqController -f verilog.f > build.log 2>&1 ||
  { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_irqController > sim.log 2>&1 ||
  echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1 ||
  grep -q "Verification passed" sim.log || exit 1

//--- tb_irqController.sv
`timescale 1ns/10ps
`default_nettype none

`include "irq_settings.svh"

module tb_irqController;

  localparam int MAX_CYCLES = 2000; // Tests need about 300 cycles.
  localparam logic [`IRQ_ADDR_W-1:0] addrImask = 3'd0;
  localparam logic [`IRQ_ADDR_W-1:0] addrIcntl = 3'd1;
  localparam logic [`IRQ_ADDR_W-1:0] addrIfc = 3'd2;
  localparam logic [`IRQ_ADDR_W-1:0] addrIflag = 3'd3;

  logic DSPCLK = 1'b0;
  logic SRST;
  logic pSel, pEnable, pWrite, pReady, pSlvErr;
  logic [`IRQ_ADDR_W-1:0] pAddr;
  logic [15:0] pWData, pRData;
  logic [`IRQ_NUM_EXT-1:0] irqExtN;
  logic [`IRQ_NUM_SRC-`IRQ_NUM_EXT-1:0] irqEvent;
  logic trapAck, rtiDone, trapReq;
  logic [`IRQ_VEC_W-1:0] vecAddr;
  int errCnt = 0;
  int checkCnt = 0;
  int cycleCnt = 0;
  int seed = 91343;
  logic expectQuiet = 1'b0; // No request may rise while set.
  logic [15:0] rd;
  logic err;

  irqController i_dut (
    .DSPCLK (DSPCLK), .SRST (SRST),
    .pSel_i (pSel), .pEnable_i (pEnable), .pWrite_i (pWrite), .pAddr_i (pAddr),
    .pWData_i (pWData), .pRData_o (pRData), .pReady_o (pReady), .pSlvErr_o (pSlvErr),
    .irqExtN_i (irqExtN), .irqEvent_i (irqEvent),
    .trapAck_i (trapAck), .rtiDone_i (rtiDone),
    .trapReq_o (trapReq), .vecAddr_o (vecAddr)
  );

  always #5 DSPCLK = ~DSPCLK;

  always @(posedge DSPCLK) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt == MAX_CYCLES) begin
      $display("Timeout after %0d cycles, %0d errors so far", cycleCnt, errCnt);
      $display("Verification failed");
      $finish;
    end
  end

  readyHigh: assert property (@(posedge DSPCLK) disable iff (SRST) pReady) else begin
    errCnt++;
    $display("APB ready went low");
  end

  quietReq: assert property (@(posedge DSPCLK) disable iff (SRST) expectQuiet |-> !trapReq)
    else begin
      errCnt++;
      $display("Trap request raised while no unmasked source was pending");
    end

  // Mask bits kept by a nested acknowledge of source src.
  function automatic logic [15:0] nestedMask(input logic [15:0] mask, input int src);
    logic [15:0] keep;
    keep = '0;
    for (int i = src + 1; i < `IRQ_NUM_SRC; i++) begin
      keep[i] = 1'b1;
    end
    return mask & keep;
  endfunction

  task automatic checkVal(input string name, input logic [15:0] exp, input logic [15:0] act);
    checkCnt++;
    valueCheck: assert (act === exp) else begin
      errCnt++;
      $display("Error %s: expected 0x%04h, actual 0x%04h", name, exp, act);
    end
  endtask

  task automatic apbAccess(input logic wr, input logic [`IRQ_ADDR_W-1:0] addr,
                           input logic [15:0] data, output logic [15:0] rdata,
                           output logic slvErr);
    @(posedge DSPCLK);
    pSel <= 1'b1; // Setup phase.
    pWrite <= wr;
    pAddr <= addr;
    pWData <= data;
    @(posedge DSPCLK);
    pEnable <= 1'b1;
    @(negedge DSPCLK);
    rdata = pRData;
    slvErr = pSlvErr;
    @(posedge DSPCLK); // Write lands here.
    pSel <= 1'b0;
    pEnable <= 1'b0;
    pWrite <= 1'b0;
  endtask

  task automatic writeReg(input logic [`IRQ_ADDR_W-1:0] addr, input logic [15:0] data);
    apbAccess(1'b1, addr, data, rd, err);
    checkVal("write error flag", 16'h0000, 16'(err));
  endtask

  task automatic readCheck(input string name, input logic [`IRQ_ADDR_W-1:0] addr,
                           input logic [15:0] exp);
    apbAccess(1'b0, addr, 16'h0000, rd, err);
    checkVal(name, exp, rd);
    checkVal({name, " error flag"}, 16'h0000, 16'(err));
  endtask

  // Polls the core outputs until they match or the limit runs out.
  task automatic waitOut(input string name, input logic expReq,
                         input logic [`IRQ_VEC_W-1:0] expVec, input int limit);
    int n;
    n = 0;
    @(negedge DSPCLK);
    while ((trapReq !== expReq || vecAddr !== expVec) && n < limit) begin
      @(negedge DSPCLK);
      n++;
    end
    checkVal({name, " request"}, 16'(expReq), 16'(trapReq));
    checkVal({name, " vector"}, 16'(expVec), 16'(vecAddr));
  endtask

  task automatic pulseAck();
    @(posedge DSPCLK);
    trapAck <= 1'b1;
    @(posedge DSPCLK);
    trapAck <= 1'b0;
  endtask

  task automatic pulseRti();
    @(posedge DSPCLK);
    rtiDone <= 1'b1;
    @(posedge DSPCLK);
    rtiDone <= 1'b0;
  endtask

  initial begin
    logic [4:0] evBits;
    SRST <= 1'b1;
    pSel <= 1'b0;
    pEnable <= 1'b0;
    pWrite <= 1'b0;
    pAddr <= '0;
    pWData <= '0;
    irqExtN <= '1; // Lines idle high.
    irqEvent <= '0;
    trapAck <= 1'b0;
    rtiDone <= 1'b0;
    repeat (2) @(posedge DSPCLK);
    SRST <= 1'b0;

    readCheck("reset IMASK", addrImask, 16'h0000);
    readCheck("reset ICNTL", addrIcntl, 16'h0010);
    readCheck("reset IFLAG", addrIflag, 16'h0000);
    waitOut("reset", 1'b0, 14'd0, 0);

    writeReg(addrImask, 16'h005A);
    readCheck("IMASK readback", addrImask, 16'h005A);
    writeReg(addrIcntl, 16'h001B);
    readCheck("ICNTL readback", addrIcntl, 16'h001B);
    readCheck("IFC readback", addrIfc, 16'h0000);
    apbAccess(1'b0, 3'd5, 16'h0000, rd, err);
    checkVal("bad address read error", 16'h0001, 16'(err));
    apbAccess(1'b1, 3'd5, 16'hFFFF, rd, err);
    checkVal("bad address write error", 16'h0001, 16'(err));
    readCheck("IMASK after bad write", addrImask, 16'h005A);
    readCheck("ICNTL after bad write", addrIcntl, 16'h001B);
    readCheck("IFLAG after bad write", addrIflag, 16'h0000);

    writeReg(addrIcntl, 16'h0017); // Edge mode, so the force on source 2 holds.
    writeReg(addrImask, 16'h0044);
    writeReg(addrIfc, 16'h4400);
    waitOut("force 2 and 6", 1'b1, 14'd28, 4);
    writeReg(addrIfc, 16'h0040);
    waitOut("clear 6", 1'b1, 14'd12, 4);
    writeReg(addrIcntl, 16'h0007);
    waitOut("global disable", 1'b0, 14'd0, 4);
    readCheck("IFLAG while disabled", addrIflag, 16'h0004);
    writeReg(addrIfc, 16'h00FF);

    writeReg(addrIcntl, 16'h0018); // Nesting on.
    writeReg(addrImask, 16'h00E8);
    writeReg(addrIfc, 16'h2000);
    waitOut("nested request", 1'b1, 14'd24, 4);
    pulseAck();
    waitOut("nested ack", 1'b0, 14'd0, 4);
    readCheck("IMASK nested", addrImask, nestedMask(16'h00E8, 5));
    readCheck("IFLAG after ack", addrIflag, 16'h0000);
    pulseRti();
    readCheck("IMASK after nested return", addrImask, 16'h00E8);
    writeReg(addrIcntl, 16'h0010);
    writeReg(addrIfc, 16'h2000);
    waitOut("flat request", 1'b1, 14'd24, 4);
    pulseAck();
    waitOut("flat ack", 1'b0, 14'd0, 4);
    readCheck("IMASK flat", addrImask, 16'h0000);
    pulseRti();
    readCheck("IMASK after flat return", addrImask, 16'h00E8);

    writeReg(addrIcntl, 16'h0011); // Line 0 in edge mode.
    writeReg(addrImask, 16'h0001);
    @(posedge DSPCLK);
    irqExtN <= 3'b110;
    waitOut("edge set", 1'b1, 14'd4, 4);
    pulseAck();
    waitOut("edge ack", 1'b0, 14'd0, 4);
    expectQuiet = 1'b1;
    pulseRti();
    readCheck("IFLAG edge held low", addrIflag, 16'h0000);
    expectQuiet = 1'b0;
    writeReg(addrIcntl, 16'h0010);
    waitOut("level set", 1'b1, 14'd4, 4);
    pulseAck();
    waitOut("level ack", 1'b0, 14'd0, 4);
    readCheck("IFLAG level held low", addrIflag, 16'h0001);
    pulseRti();
    waitOut("level return", 1'b1, 14'd4, 4);
    @(posedge DSPCLK);
    irqExtN <= 3'b111;
    waitOut("line released", 1'b0, 14'd0, 6);

    writeReg(addrImask, 16'h0007); // Event sources all masked.
    expectQuiet = 1'b1;
    repeat (8) begin
      evBits = 5'($random(seed));
      if (evBits == 5'd0) begin
        evBits = 5'd1;
      end
      @(posedge DSPCLK);
      irqEvent <= evBits;
      @(posedge DSPCLK);
      irqEvent <= '0;
      readCheck("masked event IFLAG", addrIflag, {8'h00, evBits, 3'b000});
      writeReg(addrIfc, 16'h00F8);
    end
    expectQuiet = 1'b0;

    $display("Checks: %0d, errors: %0d", checkCnt, errCnt);
    if (errCnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- irqController.sv
`timescale 1ns/10ps
`default_nettype none

`include "irq_settings.svh"

module irqController (
  input wire logic DSPCLK,
  input wire logic SRST,
  // APB slave.
  input wire logic pSel_i,
  input wire logic pEnable_i,
  input wire logic pWrite_i,
  input wire logic [`IRQ_ADDR_W-1:0] pAddr_i,
  input wire logic [15:0] pWData_i,
  output logic [15:0] pRData_o,
  output logic pReady_o,
  output logic pSlvErr_o,
  // Interrupt sources.
  input wire logic [`IRQ_NUM_EXT-1:0] irqExtN_i, // Active low.
  input wire logic [`IRQ_NUM_SRC-`IRQ_NUM_EXT-1:0] irqEvent_i,
  // Core side.
  input wire logic trapAck_i,
  input wire logic rtiDone_i,
  output logic trapReq_o,
  output logic [`IRQ_VEC_W-1:0] vecAddr_o
);

  irqRegBus regBus ();
  irqArbBus arbBus ();

  irqRegDecode i_regDecode (
    .DSPCLK (DSPCLK),
    .SRST (SRST),
    .pSel_i (pSel_i),
    .pEnable_i (pEnable_i),
    .pWrite_i (pWrite_i),
    .pAddr_i (pAddr_i),
    .pWData_i (pWData_i),
    .pRData_o (pRData_o),
    .pReady_o (pReady_o),
    .pSlvErr_o (pSlvErr_o),
    .regBus (regBus.decode)
  );

  irqFlagUnit i_flagUnit (
    .DSPCLK (DSPCLK),
    .SRST (SRST),
    .irqExtN_i (irqExtN_i),
    .irqEvent_i (irqEvent_i),
    .trapAck_i (trapAck_i),
    .rtiDone_i (rtiDone_i),
    .regBus (regBus.flags),
    .arbBus (arbBus.flags)
  );

  irqPriority i_priority (
    .DSPCLK (DSPCLK),
    .SRST (SRST),
    .arbBus (arbBus.prio),
    .trapReq_o (trapReq_o),
    .vecAddr_o (vecAddr_o)
  );

endmodule

`default_nettype wire

//--- irqPriority.sv
`timescale 1ns/10ps
`default_nettype none

`include "irq_settings.svh"

module irqPriority (
  input wire logic DSPCLK,
  input wire logic SRST,
  irqArbBus.prio arbBus,
  output logic trapReq_o,
  output logic [`IRQ_VEC_W-1:0] vecAddr_o
);

  localparam int N = `IRQ_NUM_SRC;
  localparam int VEC_W = `IRQ_VEC_W;

  logic [N-1:0] pick;
  logic [N-1:0] chosen;
  logic [VEC_W-1:0] vecNext;
  logic anyReq;

  // Highest index wins, so later hits overwrite earlier ones.
  always_comb begin
    pick = '0;
    vecNext = '0;
    for (int i = 0; i < N; i++) begin
      if (arbBus.pendMasked[i]) begin
        pick = '0;
        pick[i] = 1'b1;
        vecNext = VEC_W'((i + 1) * `IRQ_VEC_STEP);
      end
    end
  end

  assign anyReq = arbBus.globalEn && (|arbBus.pendMasked);

  always_ff @(posedge DSPCLK or posedge SRST) begin
    if (SRST) begin
      chosen <= '0;
      trapReq_o <= 1'b0;
      vecAddr_o <= '0;
    end else begin
      chosen <= anyReq ? pick : '0;
      trapReq_o <= anyReq;
      vecAddr_o <= anyReq ? vecNext : '0; // Vector 0 means idle.
    end
  end

  assign arbBus.chosenOneHot = chosen;

  // The latched choice names at most one source.
  choiceOneHot: assert property (
    @(posedge DSPCLK) disable iff (SRST)
    $onehot0(chosen)
  );

endmodule

`default_nettype wire

//--- irqFlagUnit.sv
`timescale 1ns/10ps
`default_nettype none

`include "irq_settings.svh"

module irqFlagUnit (
  input wire logic DSPCLK,
  input wire logic SRST,
  input wire logic [`IRQ_NUM_EXT-1:0] irqExtN_i,
  input wire logic [`IRQ_NUM_SRC-`IRQ_NUM_EXT-1:0] irqEvent_i,
  input wire logic trapAck_i,
  input wire logic rtiDone_i,
  irqRegBus.flags regBus,
  irqArbBus.flags arbBus
);

  localparam int N = `IRQ_NUM_SRC;
  localparam int EXT_W = `IRQ_NUM_EXT;
  localparam int EVT_W = `IRQ_NUM_SRC - `IRQ_NUM_EXT;
  localparam int DEPTH = `IRQ_STACK_DEPTH;
  localparam int STK_AW = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [EXT_W-1:0] extSync1, extSync2, extDly;
  logic [N-1:0] iflag, imask;
  logic [N-1:0] rawSet, setVec, clrVec, isLevel, levelVal;
  logic [N-1:0] aboveMask;
  logic [15:0] wrWord;
  irqPkg::ctrl_t ctrl;
  logic [N-1:0] maskStack [DEPTH];
  logic [CNT_W-1:0] stkCnt;
  logic [STK_AW-1:0] topIdx;
  logic stkFull, stkEmpty;

  // Two-flop synchroniser on the inverted lines, then an edge tap.
  always_ff @(posedge DSPCLK or posedge SRST) begin
    if (SRST) begin
      extSync1 <= '0;
      extSync2 <= '0;
      extDly <= '0;
    end else begin
      extSync1 <= ~irqExtN_i;
      extSync2 <= extSync1;
      extDly <= extSync2;
    end
  end

  assign wrWord = regBus.wrData;
  assign rawSet = {irqEvent_i, extSync2 & ~extDly};
  assign setVec = rawSet | (regBus.wrIfc ? regBus.wrData.ifc.forceBits : '0);
  assign clrVec = (trapAck_i ? arbBus.chosenOneHot : '0) |
                  (regBus.wrIfc ? regBus.wrData.ifc.clearBits : '0);
  assign isLevel = {{EVT_W{1'b0}}, ~ctrl.edgeSel};
  assign levelVal = {{EVT_W{1'b0}}, extSync2};

  // Edge flags: clear wins over set. Level flags track the line.
  always_ff @(posedge DSPCLK or posedge SRST) begin
    if (SRST) begin
      iflag <= '0;
    end else begin
      iflag <= (isLevel & levelVal) | (~isLevel & (iflag | setVec) & ~clrVec);
    end
  end

  always_ff @(posedge DSPCLK or posedge SRST) begin
    if (SRST) begin
      ctrl <= '{globalEn: 1'b1, nestEn: 1'b0, edgeSel: '0};
    end else if (regBus.wrCtrl) begin
      ctrl <= regBus.wrData.ctrl.cfg;
    end
  end

  // Bits strictly above the source being taken.
  assign aboveMask = ~((arbBus.chosenOneHot - 1'b1) | arbBus.chosenOneHot);

  assign stkFull = (stkCnt == CNT_W'(DEPTH));
  assign stkEmpty = (stkCnt == '0);
  assign topIdx = STK_AW'(stkCnt - 1'b1);

  always_ff @(posedge DSPCLK or posedge SRST) begin
    if (SRST) begin
      imask <= '0;
      stkCnt <= '0;
    end else if (trapAck_i) begin
      imask <= ctrl.nestEn ? (imask & aboveMask) : '0;
      if (!stkFull) begin
        stkCnt <= stkCnt + 1'b1;
      end
    end else if (rtiDone_i && !stkEmpty) begin
      imask <= maskStack[topIdx]; // Restore.
      stkCnt <= stkCnt - 1'b1;
    end else if (regBus.wrMask) begin
      imask <= wrWord[N-1:0];
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (trapAck_i && !stkFull) begin
      maskStack[stkCnt[STK_AW-1:0]] <= imask;
    end
  end

  assign regBus.imask = imask;
  assign regBus.ctrl = ctrl;
  assign regBus.iflag = iflag;
  assign arbBus.pendMasked = iflag & imask;
  assign arbBus.globalEn = ctrl.globalEn;

  // The core only acknowledges a registered choice.
  ackHasChoice: assert property (
    @(posedge DSPCLK) disable iff (SRST)
    trapAck_i |-> (arbBus.chosenOneHot != '0)
  );

  // Every return matches an earlier acknowledge.
  rtiNotEmpty: assert property (
    @(posedge DSPCLK) disable iff (SRST)
    rtiDone_i |-> !stkEmpty
  );

endmodule

`default_nettype wire

//--- irqRegDecode.sv
`timescale 1ns/10ps
`default_nettype none

`include "irq_settings.svh"

module irqRegDecode (
  input wire logic DSPCLK,
  input wire logic SRST,
  input wire logic pSel_i,
  input wire logic pEnable_i,
  input wire logic pWrite_i,
  input wire logic [`IRQ_ADDR_W-1:0] pAddr_i,
  input wire logic [15:0] pWData_i,
  output logic [15:0] pRData_o,
  output logic pReady_o,
  output logic pSlvErr_o,
  irqRegBus.decode regBus
);

  logic access;
  logic wrAccess;
  logic addrOk;
  logic [15:0] rdData;
  irqPkg::regAddr_e addr;

  assign access = pSel_i && pEnable_i; // Access phase.
  assign wrAccess = access && pWrite_i;
  assign addr = irqPkg::regAddr_e'(pAddr_i);

  // Strobes fire in the access cycle and land at its closing edge.
  assign regBus.wrMask = wrAccess && (addr == irqPkg::IMASK);
  assign regBus.wrCtrl = wrAccess && (addr == irqPkg::ICNTL);
  assign regBus.wrIfc = wrAccess && (addr == irqPkg::IFC);
  assign regBus.wrData = irqPkg::regWord_u'(pWData_i);

  always_comb begin
    addrOk = 1'b1;
    rdData = '0;
    case (addr)
      irqPkg::IMASK: rdData = 16'(regBus.imask);
      irqPkg::ICNTL: rdData = 16'(regBus.ctrl);
      irqPkg::IFC: rdData = '0; // Strobe register.
      irqPkg::IFLAG: rdData = 16'(regBus.iflag);
      default: addrOk = 1'b0;
    endcase
  end

  assign pRData_o = (access && !pWrite_i) ? rdData : '0;
  assign pSlvErr_o = access && !addrOk;
  assign pReady_o = 1'b1; // Zero wait states.

  // Only one register may be written per transfer.
  oneStrobe: assert property (
    @(posedge DSPCLK) disable iff (SRST)
    $onehot0({regBus.wrMask, regBus.wrCtrl, regBus.wrIfc})
  );

endmodule

`default_nettype wire

//--- irqArbBus.sv
`timescale 1ns/10ps
`default_nettype none

`include "irq_settings.svh"

interface irqArbBus;

  logic [`IRQ_NUM_SRC-1:0] pendMasked; // Flags and mask combined.
  logic globalEn;
  logic [`IRQ_NUM_SRC-1:0] chosenOneHot; // Registered choice.

  modport flags (
    output pendMasked, globalEn,
    input chosenOneHot
  );

  modport prio (
    input pendMasked, globalEn,
    output chosenOneHot
  );

endinterface

`default_nettype wire

//--- irqRegBus.sv
`timescale 1ns/10ps
`default_nettype none

`include "irq_settings.svh"

interface irqRegBus;

  // Write side.
  logic wrMask;
  logic wrCtrl;
  logic wrIfc;
  irqPkg::regWord_u wrData;

  // Read-back side.
  logic [`IRQ_NUM_SRC-1:0] imask;
  irqPkg::ctrl_t ctrl;
  logic [`IRQ_NUM_SRC-1:0] iflag;

  modport decode (
    output wrMask, wrCtrl, wrIfc, wrData,
    input imask, ctrl, iflag
  );

  modport flags (
    input wrMask, wrCtrl, wrIfc, wrData,
    output imask, ctrl, iflag
  );

endinterface

`default_nettype wire

//--- irqPkg.sv
`default_nettype none

`include "irq_settings.svh"

package irqPkg;

  // Interrupt control word.
  typedef struct packed {
    logic globalEn;
    logic nestEn;
    logic [`IRQ_NUM_EXT-1:0] edgeSel; // 1 selects edge mode.
  } ctrl_t;

  // Force/clear layout of a written word.
  typedef struct packed {
    logic [`IRQ_NUM_SRC-1:0] forceBits;
    logic [`IRQ_NUM_SRC-1:0] clearBits;
  } ifcView_t;

  // Control layout of a written word.
  typedef struct packed {
    logic [16-$bits(ctrl_t)-1:0] rsvd;
    ctrl_t cfg;
  } ctrlView_t;

  // Write data, decoded per target register.
  typedef union packed {
    ifcView_t ifc;
    ctrlView_t ctrl;
  } regWord_u;

  // Register map.
  typedef enum logic [`IRQ_ADDR_W-1:0] {
    IMASK = 0,
    ICNTL = 1,
    IFC = 2,   // Write only.
    IFLAG = 3  // Read only.
  } regAddr_e;

endpackage

`default_nettype wire

//--- irq_settings.svh
`ifndef IRQ_SETTINGS_SVH
`define IRQ_SETTINGS_SVH

// Source layout. External lines occupy the low indices.
`define IRQ_NUM_SRC 8
`define IRQ_NUM_EXT 3

// APB word address width.
`define IRQ_ADDR_W 3

// Vector output.
`define IRQ_VEC_W 14
`define IRQ_VEC_STEP 4 // Words between vectors.

// Saved masks for nested service.
`define IRQ_STACK_DEPTH 4

`endif
